//--- project.f
rtl/dcache_pkg.sv
rtl/dcache_tag_array.sv
rtl/dcache_data_array.sv
rtl/dcache_ctrl.sv
rtl/dcache.sv
tb/dcache_mem.sv
tb/dcache_tb.sv

//--- Makefile
# Verilator flow for the data cache
# override any variable on the command line, e.g. make sim JOBS=8

VERILATOR  ?= verilator
TOP        ?= dcache_tb
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 4
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the binary exits non-zero when the testbench calls $fatal
sim:
	$(VERILATOR) --binary --timing --assert $(SIM_FLAGS) -j $(JOBS) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/dcache_tb.sv
`default_nettype none

module dcache_tb
  import dcache_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam word_t COUNT_ADDR = 32'h3100;
  localparam int    TIMEOUT    = 200;
  localparam int    N_REQ      = 200;

  logic  CLK;
  logic  nRST;
  logic  halt;
  logic  dren;
  logic  dwen;
  word_t daddr;
  word_t dstore;
  logic  dhit;
  word_t dload;
  logic  flushed;
  logic  mem_ren;
  logic  mem_wen;
  word_t mem_addr;
  word_t mem_store;
  word_t mem_load;
  logic  mem_wait;
  logic  stall;

  // reference model of the cache
  logic [TAG_W-1:0] model_tag [N_SETS][2];
  logic             model_valid [N_SETS][2];
  logic             model_dirty [N_SETS][2];
  logic             model_lru [N_SETS];
  // what the cpu should see at each memory word
  word_t            shadow [256];
  // hits on first presentation only
  int               hits;
  logic [15:0]      lfsr;

  dcache #(.COUNT_ADDR(COUNT_ADDR)) dcache_i (
    .CLK(CLK), .nRST(nRST), .halt(halt), .dren(dren), .dwen(dwen),
    .daddr(daddr), .dstore(dstore), .dhit(dhit), .dload(dload), .flushed(flushed),
    .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_store(mem_store),
    .mem_load(mem_load), .mem_wait(mem_wait)
  );

  dcache_mem #(.COUNT_ADDR(COUNT_ADDR)) mem_i (
    .CLK(CLK), .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
    .mem_store(mem_store), .mem_load(mem_load), .mem_wait(mem_wait), .stall(stall)
  );

  always #50 CLK = ~CLK;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic next_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic word_t draw_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[WORD_W-2:0], next_bit()};
    end
    return v;
  endfunction

  // same pattern the memory starts with
  function automatic word_t initial_word(input logic [7:0] a);
    return {a, ~a, a ^ 8'h5a, 8'hc3 ^ {a[3:0], a[7:4]}};
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic timed_out(input string what);
    $display("no %s within %0d cycles", what, TIMEOUT);
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  endtask

  // one clock and a fresh wait state draw (about one in four)
  task automatic tick();
    @(posedge CLK);
    stall <= (draw_bits(2) == 32'd3);
  endtask

  task automatic access(input logic wr, input word_t addr, input word_t data);
    logic [IDX_W-1:0] set;
    logic [TAG_W-1:0] tag;
    logic [7:0]       widx;
    logic             exp_hit;
    logic             way;
    int               n;
    set     = addr[5:3];
    tag     = addr[31:6];
    widx    = addr[9:2];
    exp_hit = 1'b0;
    way     = 1'b0;
    for (int w = 0; w < 2; w++)
    begin
      if (model_valid[set][w] && model_tag[set][w] == tag)
      begin
        exp_hit = 1'b1;
        way     = w[0];
      end
    end
    tick();
    dren   <= !wr;
    dwen   <= wr;
    daddr  <= addr;
    dstore <= data;
    // lookup has settled by mid cycle
    @(negedge CLK);
    check_value("dhit", 32'(dhit), 32'(exp_hit));
    if (exp_hit)
    begin
      hits = hits + 1;
    end
    else
    begin
      way = model_lru[set];
      tick();
      @(negedge CLK);
      // dirty victim goes out before the fill
      check_value("mem_wen", 32'(mem_wen), 32'(model_dirty[set][way]));
      check_value("mem_ren", 32'(mem_ren), 32'(!model_dirty[set][way]));
      n = 0;
      while (!dhit)
      begin
        if (n == TIMEOUT)
        begin
          timed_out("dhit after a miss");
        end
        tick();
        @(negedge CLK);
        n++;
      end
      model_tag[set][way]   = tag;
      model_valid[set][way] = 1'b1;
      model_dirty[set][way] = 1'b0;
    end
    if (wr)
    begin
      shadow[widx]          = data;
      model_dirty[set][way] = 1'b1;
    end
    else
    begin
      check_value("dload", dload, shadow[widx]);
    end
    model_lru[set] = !way;
    // this edge still sees the request
    tick();
    dren <= 1'b0;
    dwen <= 1'b0;
  endtask

  initial
  begin
    logic  wr;
    word_t a;
    word_t addr;
    int    n;
    CLK    = 1'b0;
    nRST   = 1'b0;
    halt   = 1'b0;
    dren   = 1'b0;
    dwen   = 1'b0;
    daddr  = '0;
    dstore = '0;
    stall  = 1'b0;
    lfsr   = 16'd70;
    hits   = 0;
    for (int s = 0; s < N_SETS; s++)
    begin
      model_lru[s] = 1'b0;
      for (int w = 0; w < 2; w++)
      begin
        model_tag[s][w]   = '0;
        model_valid[s][w] = 1'b0;
        model_dirty[s][w] = 1'b0;
      end
    end
    for (int i = 0; i < 256; i++)
    begin
      shadow[i] = initial_word(8'(i));
    end
    repeat (4) tick();
    nRST <= 1'b1;
    @(negedge CLK);
    check_value("mem_ren", 32'(mem_ren), 32'd0);
    check_value("mem_wen", 32'(mem_wen), 32'd0);
    check_value("flushed", 32'(flushed), 32'd0);

    // four tags over sets 0 to 3 keep evicting ways
    for (int k = 0; k < N_REQ; k++)
    begin
      // first request reads the cold cache
      wr      = next_bit() && (k != 0);
      a       = draw_bits(5);
      addr    = '0;
      addr[7:6] = a[4:3];
      addr[4:3] = a[2:1];
      addr[2]   = a[0];
      access(wr, addr, draw_bits(32));
    end

    tick();
    halt <= 1'b1;
    @(negedge CLK);
    n = 0;
    while (!flushed)
    begin
      if (n == TIMEOUT)
      begin
        timed_out("flushed after halt");
      end
      tick();
      @(negedge CLK);
      n++;
    end
    // everything dirty should be back in memory now
    for (int i = 0; i < 256; i++)
    begin
      check_value($sformatf("mem[%0d]", i), mem_i.words[i], shadow[i]);
    end
    check_value("hit count", mem_i.count_word, 32'(hits));
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/dcache_mem.sv
`default_nettype none

module dcache_mem
  import dcache_pkg::*;
#(
  parameter word_t COUNT_ADDR = 32'h3100
)
(
  input  wire logic  CLK,
  input  wire logic  mem_ren,
  input  wire logic  mem_wen,
  input  wire word_t mem_addr,
  input  wire word_t mem_store,
  output word_t      mem_load,
  output logic       mem_wait,
  // wait state request, drawn by the testbench each cycle
  input  wire logic  stall
);

  timeunit 1ns;
  timeprecision 100ps;

  // 256 words, byte address bits 9:2
  word_t      words [256];
  // hit count lands here, apart from the array
  word_t      count_word;
  logic [7:0] widx;

  // every bit of the word address shows up in the pattern
  function automatic word_t fill_word(input logic [7:0] a);
    return {a, ~a, a ^ 8'h5a, 8'hc3 ^ {a[3:0], a[7:4]}};
  endfunction

  initial
  begin
    for (int i = 0; i < 256; i++)
    begin
      words[i] = fill_word(8'(i));
    end
    count_word = '0;
  end

  assign widx     = mem_addr[9:2];
  assign mem_load = mem_ren ? words[widx] : '0;
  // only stall a live transfer
  assign mem_wait = stall && (mem_ren || mem_wen);

  always @(posedge CLK)
  begin
    if (mem_wen && !stall)
    begin
      if (mem_addr == COUNT_ADDR)
      begin
        count_word <= mem_store;
      end
      else
      begin
        words[widx] <= mem_store;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/dcache.sv
`default_nettype none

module dcache
  import dcache_pkg::*;
#(
  parameter word_t COUNT_ADDR = 32'h3100
)
(
  input  wire logic  CLK,
  input  wire logic  nRST,
  // cpu side
  input  wire logic  halt,
  input  wire logic  dren,
  input  wire logic  dwen,
  input  wire addr_t daddr,
  input  wire word_t dstore,
  output logic       dhit,
  output word_t      dload,
  output logic       flushed,
  // memory side
  output logic       mem_ren,
  output logic       mem_wen,
  output word_t      mem_addr,
  output word_t      mem_store,
  input  wire word_t mem_load,
  input  wire logic  mem_wait
);

  // lookup results
  logic             hit;
  logic             hit_way;
  logic             victim_way;
  logic             victim_dirty;
  logic [TAG_W-1:0] victim_tag;
  // tag array updates
  logic             touch;
  logic             touch_dirty;
  logic             fill_done;
  logic             victim_clean;
  logic             scan_clean;
  // halt walk
  logic [IDX_W-1:0] scan_set;
  logic             scan_way;
  logic             scan_dirty;
  logic [TAG_W-1:0] scan_tag;
  // data array ports
  logic [IDX_W-1:0] wb_set;
  logic             wb_way;
  logic             wb_word;
  word_t            wb_data;
  logic             wr_en;
  logic [IDX_W-1:0] wr_set;
  logic             wr_way;
  logic             wr_word;
  word_t            wr_data;

  dcache_tag_array tags_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .req_addr     (daddr),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .touch        (touch),
    .touch_dirty  (touch_dirty),
    .fill_done    (fill_done),
    .victim_clean (victim_clean),
    .scan_set     (scan_set),
    .scan_way     (scan_way),
    .scan_dirty   (scan_dirty),
    .scan_tag     (scan_tag),
    .scan_clean   (scan_clean)
  );

  // cpu read follows the hitting way
  dcache_data_array data_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .rd_addr (daddr),
    .rd_way  (hit_way),
    .rd_data (dload),
    .wb_set  (wb_set),
    .wb_way  (wb_way),
    .wb_word (wb_word),
    .wb_data (wb_data),
    .wr_en   (wr_en),
    .wr_set  (wr_set),
    .wr_way  (wr_way),
    .wr_word (wr_word),
    .wr_data (wr_data)
  );

  dcache_ctrl #(
    .COUNT_ADDR (COUNT_ADDR)
  ) ctrl_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .halt         (halt),
    .dren         (dren),
    .dwen         (dwen),
    .daddr        (daddr),
    .dstore       (dstore),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .scan_tag     (scan_tag),
    .scan_dirty   (scan_dirty),
    .dhit         (dhit),
    .touch        (touch),
    .touch_dirty  (touch_dirty),
    .fill_done    (fill_done),
    .victim_clean (victim_clean),
    .scan_clean   (scan_clean),
    .scan_set     (scan_set),
    .scan_way     (scan_way),
    .wb_set       (wb_set),
    .wb_way       (wb_way),
    .wb_word      (wb_word),
    .wb_data      (wb_data),
    .wr_en        (wr_en),
    .wr_set       (wr_set),
    .wr_way       (wr_way),
    .wr_word      (wr_word),
    .wr_data      (wr_data),
    .mem_ren      (mem_ren),
    .mem_wen      (mem_wen),
    .mem_addr     (mem_addr),
    .mem_store    (mem_store),
    .mem_load     (mem_load),
    .mem_wait     (mem_wait),
    .flushed      (flushed)
  );

endmodule

`default_nettype wire

//--- rtl/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl
  import dcache_pkg::*;
#(
  parameter word_t COUNT_ADDR = 32'h3100
)
(
  input  wire logic             CLK,
  input  wire logic             nRST,
  // cpu request
  input  wire logic             halt,
  input  wire logic             dren,
  input  wire logic             dwen,
  input  wire addr_t            daddr,
  input  wire word_t            dstore,
  // tag array lookup
  input  wire logic             hit,
  input  wire logic             hit_way,
  input  wire logic             victim_way,
  input  wire logic             victim_dirty,
  input  wire logic [TAG_W-1:0] victim_tag,
  input  wire logic [TAG_W-1:0] scan_tag,
  input  wire logic             scan_dirty,
  output logic                  dhit,
  // tag array updates
  output logic                  touch,
  output logic                  touch_dirty,
  output logic                  fill_done,
  output logic                  victim_clean,
  output logic                  scan_clean,
  output logic [IDX_W-1:0]      scan_set,
  output logic                  scan_way,
  // data array ports
  output logic [IDX_W-1:0]      wb_set,
  output logic                  wb_way,
  output logic                  wb_word,
  input  wire word_t            wb_data,
  output logic                  wr_en,
  output logic [IDX_W-1:0]      wr_set,
  output logic                  wr_way,
  output logic                  wr_word,
  output word_t                 wr_data,
  // memory bus
  output logic                  mem_ren,
  output logic                  mem_wen,
  output word_t                 mem_addr,
  output word_t                 mem_store,
  input  wire word_t            mem_load,
  input  wire logic             mem_wait,
  output logic                  flushed
);

  // one state per memory word
  localparam logic [3:0] IDLE      = 4'd0;
  localparam logic [3:0] WB0       = 4'd1;
  localparam logic [3:0] WB1       = 4'd2;
  localparam logic [3:0] FILL0     = 4'd3;
  localparam logic [3:0] FILL1     = 4'd4;
  localparam logic [3:0] SCAN      = 4'd5;
  localparam logic [3:0] FLUSH0    = 4'd6;
  localparam logic [3:0] FLUSH1    = 4'd7;
  localparam logic [3:0] STORE_CNT = 4'd8;
  localparam logic [3:0] DONE      = 4'd9;

  logic [3:0] state;
  logic [3:0] next_state;
  // frame pointer for the halt walk, {set, way}
  logic [3:0] scan_ptr;
  logic [3:0] next_scan_ptr;
  word_t      hit_count;
  // next hit is the replay of a miss
  logic       replay;
  // bus address built in the fields view
  addr_t      mem_a;

  assign scan_set = scan_ptr[3:1];
  assign scan_way = scan_ptr[0];
  assign mem_addr = mem_a.raw;

  always_comb
  begin
    next_state    = state;
    next_scan_ptr = scan_ptr;
    dhit          = 1'b0;
    touch         = 1'b0;
    touch_dirty   = 1'b0;
    fill_done     = 1'b0;
    victim_clean  = 1'b0;
    scan_clean    = 1'b0;
    // victim frame unless flushing
    wb_set        = daddr.fields.idx;
    wb_way        = victim_way;
    wb_word       = 1'b0;
    // write port defaults to fill data
    wr_en         = 1'b0;
    wr_set        = daddr.fields.idx;
    wr_way        = victim_way;
    wr_word       = 1'b0;
    wr_data       = mem_load;
    mem_ren       = 1'b0;
    mem_wen       = 1'b0;
    mem_store     = wb_data;
    mem_a.raw     = '0;
    case (state)
      IDLE:
      begin
        if (halt)
        begin
          next_state    = SCAN;
          next_scan_ptr = '0;
        end
        else if (dren || dwen)
        begin
          if (hit)
          begin
            dhit        = 1'b1;
            touch       = 1'b1;
            touch_dirty = dwen;
            // store into the hitting frame
            wr_en       = dwen;
            wr_way      = hit_way;
            wr_word     = daddr.fields.blkoff;
            wr_data     = dstore;
          end
          else if (victim_dirty)
          begin
            next_state = WB0;
          end
          else
          begin
            next_state = FILL0;
          end
        end
      end
      WB0, WB1:
      begin
        wb_word            = (state == WB1);
        mem_wen            = 1'b1;
        mem_a.fields.tag   = victim_tag;
        mem_a.fields.idx   = daddr.fields.idx;
        mem_a.fields.blkoff = wb_word;
        if (!mem_wait)
        begin
          if (state == WB1)
          begin
            victim_clean = 1'b1;
            next_state   = FILL0;
          end
          else
          begin
            next_state = WB1;
          end
        end
      end
      FILL0, FILL1:
      begin
        wr_word             = (state == FILL1);
        mem_ren             = 1'b1;
        mem_a.fields.tag    = daddr.fields.tag;
        mem_a.fields.idx    = daddr.fields.idx;
        mem_a.fields.blkoff = wr_word;
        wr_en               = !mem_wait;
        if (!mem_wait)
        begin
          if (state == FILL1)
          begin
            // held request hits back in idle
            fill_done  = 1'b1;
            next_state = IDLE;
          end
          else
          begin
            next_state = FILL1;
          end
        end
      end
      SCAN:
      begin
        if (scan_dirty)
        begin
          next_state = FLUSH0;
        end
        else if (scan_ptr == 4'hf)
        begin
          next_state = STORE_CNT;
        end
        else
        begin
          next_scan_ptr = scan_ptr + 4'd1;
        end
      end
      FLUSH0, FLUSH1:
      begin
        wb_set              = scan_set;
        wb_way              = scan_way;
        wb_word             = (state == FLUSH1);
        mem_wen             = 1'b1;
        mem_a.fields.tag    = scan_tag;
        mem_a.fields.idx    = scan_set;
        mem_a.fields.blkoff = wb_word;
        if (!mem_wait)
        begin
          if (state == FLUSH1)
          begin
            scan_clean = 1'b1;
            // last frame goes straight to the count store
            if (scan_ptr == 4'hf)
            begin
              next_state = STORE_CNT;
            end
            else
            begin
              next_scan_ptr = scan_ptr + 4'd1;
              next_state    = SCAN;
            end
          end
          else
          begin
            next_state = FLUSH1;
          end
        end
      end
      STORE_CNT:
      begin
        mem_wen   = 1'b1;
        mem_a.raw = COUNT_ADDR;
        mem_store = hit_count;
        if (!mem_wait)
        begin
          next_state = DONE;
        end
      end
      default:
      begin
        // parked until reset
        next_state = DONE;
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state     <= IDLE;
      scan_ptr  <= '0;
      hit_count <= '0;
      replay    <= 1'b0;
      flushed   <= 1'b0;
    end
    else
    begin
      state    <= next_state;
      scan_ptr <= next_scan_ptr;
      // replayed request is not counted again
      if (dhit && !replay)
      begin
        hit_count <= hit_count + 1'b1;
      end
      if (fill_done)
      begin
        replay <= 1'b1;
      end
      else if (dhit)
      begin
        replay <= 1'b0;
      end
      if (state == STORE_CNT && !mem_wait)
      begin
        flushed <= 1'b1;
      end
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen));

  // once flushed the cache stays parked
  assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed);

endmodule

`default_nettype wire

//--- rtl/dcache_data_array.sv
`default_nettype none

module dcache_data_array
  import dcache_pkg::*;
(
  input  wire logic             CLK,
  input  wire logic             nRST,
  // cpu read port
  input  wire addr_t            rd_addr,
  input  wire logic             rd_way,
  output word_t                 rd_data,
  // writeback read port
  input  wire logic [IDX_W-1:0] wb_set,
  input  wire logic             wb_way,
  input  wire logic             wb_word,
  output word_t                 wb_data,
  // single write port, cpu store or fill
  input  wire logic             wr_en,
  input  wire logic [IDX_W-1:0] wr_set,
  input  wire logic             wr_way,
  input  wire logic             wr_word,
  input  wire word_t            wr_data
);

  // set, way, word within block
  word_t [N_SETS-1:0][1:0][BLK_WORDS-1:0] blocks;

  // both reads are combinational
  assign rd_data = blocks[rd_addr.fields.idx][rd_way][rd_addr.fields.blkoff];
  assign wb_data = blocks[wb_set][wb_way][wb_word];

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      blocks <= '0;
    end
    else if (wr_en)
    begin
      blocks[wr_set][wr_way][wr_word] <= wr_data;
    end
  end

endmodule

`default_nettype wire

//--- rtl/dcache_tag_array.sv
`default_nettype none

module dcache_tag_array
  import dcache_pkg::*;
(
  input  wire logic             CLK,
  input  wire logic             nRST,
  input  wire addr_t            req_addr,
  output logic                  hit,
  output logic                  hit_way,
  output logic                  victim_way,
  output logic                  victim_dirty,
  output logic [TAG_W-1:0]      victim_tag,
  input  wire logic             touch,
  input  wire logic             touch_dirty,
  input  wire logic             fill_done,
  input  wire logic             victim_clean,
  input  wire logic [IDX_W-1:0] scan_set,
  input  wire logic             scan_way,
  output logic                  scan_dirty,
  output logic [TAG_W-1:0]      scan_tag,
  input  wire logic             scan_clean
);

  // tag storage written only on fill
  logic [N_SETS-1:0][1:0][TAG_W-1:0] tags;
  // per frame control bits
  logic [N_SETS-1:0][1:0] valid_q;
  logic [N_SETS-1:0][1:0] dirty_q;
  // one bit per set naming the way to replace next
  logic [N_SETS-1:0]      lru_q;

  logic [IDX_W-1:0] req_idx;
  logic [TAG_W-1:0] req_tag;
  logic [1:0]       way_hit;

  assign req_idx = req_addr.fields.idx;
  assign req_tag = req_addr.fields.tag;

  // compare against both ways of the set
  assign way_hit[0] = valid_q[req_idx][0] && (tags[req_idx][0] == req_tag);
  assign way_hit[1] = valid_q[req_idx][1] && (tags[req_idx][1] == req_tag);

  assign hit     = |way_hit;
  assign hit_way = way_hit[1];

  // victim is whatever the lru bit points at
  assign victim_way   = lru_q[req_idx];
  assign victim_dirty = dirty_q[req_idx][victim_way];
  assign victim_tag   = tags[req_idx][victim_way];

  // halt walk view
  assign scan_dirty = dirty_q[scan_set][scan_way];
  assign scan_tag   = tags[scan_set][scan_way];

  always_ff @(posedge CLK)
  begin
    if (fill_done)
    begin
      tags[req_idx][victim_way] <= req_tag;
    end
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end
    else
    begin
      // hit makes the other way the next victim
      if (touch)
      begin
        lru_q[req_idx] <= ~hit_way;
        if (touch_dirty)
        begin
          dirty_q[req_idx][hit_way] <= 1'b1;
        end
      end
      if (fill_done)
      begin
        valid_q[req_idx][victim_way] <= 1'b1;
      end
      // victim written back
      if (victim_clean)
      begin
        dirty_q[req_idx][victim_way] <= 1'b0;
      end
      // frame flushed during halt
      if (scan_clean)
      begin
        dirty_q[scan_set][scan_way] <= 1'b0;
      end
    end
  end

  // fills only replace a missing tag so no set holds one twice
  assert property (@(posedge CLK) disable iff (!nRST) !(way_hit[0] && way_hit[1]));

endmodule

`default_nettype wire

//--- rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  // data and address word
  localparam int WORD_W = 32;
  typedef logic [WORD_W-1:0] word_t;

  // address field widths
  localparam int TAG_W = 26;
  localparam int IDX_W = 3;

  // cache geometry
  localparam int N_SETS    = 8;
  localparam int BLK_WORDS = 2;

  // one address word, seen raw or split into fields
  // raw goes to the memory bus, fields are decoded inside the cache
  typedef union packed {
    word_t raw;
    struct packed {
      logic [TAG_W-1:0] tag;
      logic [IDX_W-1:0] idx;
      // word within the block
      logic             blkoff;
      // always zero for word accesses
      logic [1:0]       byteoff;
    } fields;
  } addr_t;

endpackage

`default_nettype wire
